/* design/task_pkg.sv */
// Task descriptor, slot and thread types, task-type codes and the output record
package task_pkg;

   // Thread contexts in flight through the read stage
   localparam int N_THREADS = 8;
   localparam int LOG_N_THREADS = $clog2(N_THREADS);

   typedef logic [LOG_N_THREADS-1:0] thread_id_t;

   // Commit-queue slice, one undo-log entry per slot
   localparam int LOG_CQ_SLICE_SIZE = 4;
   localparam int N_SLOTS = 2 ** LOG_CQ_SLICE_SIZE;

   typedef logic [LOG_CQ_SLICE_SIZE-1:0] cq_slot_t;

   typedef logic [1:0] ttype_t;

   localparam ttype_t TASK_TYPE_NORMAL = 2'd0;             // Regular read of the named object
   localparam ttype_t TASK_TYPE_UNDO_LOG_RESTORE = 2'd3;   // Replays the slot's undo-log entry

   typedef logic [15:0] timestamp_t;
   typedef logic [15:0] object_t;
   typedef logic [31:0] data_t;

   typedef struct packed {
      ttype_t     ttype;
      logic       no_read;                                 // Skip the memory read entirely
      timestamp_t ts;
      object_t    object;                                  // Object index, scaled to a byte address
   } task_t;

   // Record leaving the read stage with the fetched word
   typedef struct packed {
      task_t      task_desc;
      cq_slot_t   cq_slot;
      thread_id_t thread;
      data_t      data;
   } rw_write_t;

endpackage

/* design/mem_pkg.sv */
// Memory address, line, request and response types, queue sizing and register map
package mem_pkg;

   // Read-write words are 2**LOG_RW_WIDTH bytes wide
   localparam int LOG_RW_WIDTH = 2;
   localparam int RW_BITS = 8 << LOG_RW_WIDTH;

   typedef logic [31:0] mem_addr_t;

   localparam int LINE_BITS = 128;
   localparam int LOG_LINE_BYTES = $clog2(LINE_BITS / 8);
   localparam int WORD_SEL_BITS = LOG_LINE_BYTES - LOG_RW_WIDTH;   // Word index inside a line

   typedef logic [LINE_BITS-1:0] line_t;

   localparam int LOG_MEM_LINES = 6;
   localparam int MEM_LINES = 2 ** LOG_MEM_LINES;
   localparam int MEM_LATENCY = 2;

   typedef logic [LOG_MEM_LINES-1:0] mem_index_t;

   typedef struct packed {
      mem_addr_t            addr;
      task_pkg::thread_id_t id;                            // Tag returned with the line
   } mem_req_t;

   typedef struct packed {
      task_pkg::thread_id_t id;
      line_t                line;
   } mem_rsp_t;

   localparam int QUEUE_LOG_DEPTH = 3;
   localparam int QUEUE_DEPTH = 2 ** QUEUE_LOG_DEPTH;

   typedef logic [QUEUE_LOG_DEPTH:0] occ_t;

   typedef struct packed {
      logic        valid;
      logic [7:0]  addr;
      logic [31:0] data;
   } cfg_wr_t;

   localparam logic [7:0] REG_RW_BASE_ADDR = 8'h10;
   localparam logic [7:0] REG_FIFO_OUT_THRESH = 8'h14;
   localparam logic [7:0] REG_N_DEQUEUES = 8'h18;

endpackage

/* design/sync_queue.sv */
// Synchronous circular-buffer FIFO with a type-parameterized payload and occupancy count
module sync_queue #(
   parameter type payload_t = logic [7:0]
) (
   input  logic          clk,
   input  logic          rstn,

   input  logic          in_valid,
   output logic          in_ready,
   input  payload_t      in_data,

   output logic          out_valid,
   input  logic          out_ready,
   output payload_t      out_data,

   output mem_pkg::occ_t occupancy
);

   payload_t buffer [mem_pkg::QUEUE_DEPTH];

   logic [mem_pkg::QUEUE_LOG_DEPTH-1:0] wr_ptr;
   logic [mem_pkg::QUEUE_LOG_DEPTH-1:0] rd_ptr;
   mem_pkg::occ_t count;
   logic push;
   logic pop;

   assign in_ready = (count != mem_pkg::occ_t'(mem_pkg::QUEUE_DEPTH));
   assign out_valid = (count != '0);
   assign out_data = buffer[rd_ptr];                       // Head is visible the cycle after the write
   assign occupancy = count;

   assign push = in_valid && in_ready;
   assign pop = out_valid && out_ready;

   always_ff @(posedge clk) begin
      if (push) begin
         buffer[wr_ptr] <= in_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;                       // Pointers wrap at the depth
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

/* design/rw_addr_gen.sv */
// Base-address register and object index to byte address translation
module rw_addr_gen (
   input  logic               clk,
   input  logic               rstn,
   input  mem_pkg::cfg_wr_t   cfg,
   input  task_pkg::task_t    task_in,
   output mem_pkg::mem_addr_t araddr
);

   mem_pkg::mem_addr_t base_addr;
   mem_pkg::mem_addr_t object_offset;

   // Objects are packed word after word from the base
   assign object_offset = mem_pkg::mem_addr_t'(task_in.object) << mem_pkg::LOG_RW_WIDTH;
   assign araddr = base_addr + object_offset;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         base_addr <= '0;
      end else begin
         if (cfg.valid && (cfg.addr == mem_pkg::REG_RW_BASE_ADDR)) begin
            base_addr <= {cfg.data[31:2], 2'b00};        // Base stays word aligned
         end
      end
   end

endmodule

/* design/object_memory.sv */
// On-chip object line memory with preload port and fixed-latency in-order read responses
module object_memory (
   input  logic                clk,
   input  logic                rstn,

   input  logic                preload_valid,
   input  mem_pkg::mem_index_t preload_index,
   input  mem_pkg::line_t      preload_line,

   input  logic                req_valid,
   output logic                req_ready,
   input  mem_pkg::mem_req_t   req,

   output logic                rsp_valid,
   input  logic                rsp_ready,
   output mem_pkg::mem_rsp_t   rsp
);

   localparam int LAT = mem_pkg::MEM_LATENCY;

   mem_pkg::line_t lines [mem_pkg::MEM_LINES];

   logic [LAT-1:0] pipe_valid;
   mem_pkg::mem_rsp_t pipe [LAT];
   mem_pkg::mem_index_t req_index;
   logic advance;

   assign req_index = req.addr[mem_pkg::LOG_LINE_BYTES +: mem_pkg::LOG_MEM_LINES];

   assign rsp_valid = pipe_valid[LAT-1];
   assign rsp = pipe[LAT-1];

   assign advance = !rsp_valid || rsp_ready;               // Whole pipeline freezes on a stalled response
   assign req_ready = (pipe_valid == '0);                  // Single read in flight

   always_ff @(posedge clk) begin
      if (preload_valid) begin
         lines[preload_index] <= preload_line;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         pipe_valid <= '0;
      end else if (advance) begin
         pipe_valid <= {pipe_valid[LAT-2:0], req_valid && req_ready};
      end
   end

   // Line is read as the request enters and then only shifts toward the output
   always_ff @(posedge clk) begin
      if (advance) begin
         pipe[0].id <= req.id;
         pipe[0].line <= lines[req_index];
         for (int i = 1; i < LAT; i++) begin
            pipe[i] <= pipe[i-1];
         end
      end
   end

endmodule

/* design/rw_read_stage.sv */
// Object read stage with dequeue gating, thread contexts, word select, undo log and bypass path
module rw_read_stage (
   input  logic                 clk,
   input  logic                 rstn,
   input  mem_pkg::cfg_wr_t     cfg,

   input  logic                 task_in_valid,
   output logic                 task_in_ready,
   input  task_pkg::task_t      task_in,
   input  task_pkg::cq_slot_t   cq_slot_in,
   input  task_pkg::thread_id_t thread_id_in,
   input  mem_pkg::mem_addr_t   araddr,

   input  logic                 gvt_slot_valid,
   input  task_pkg::cq_slot_t   gvt_slot,

   output logic                 req_valid,
   input  logic                 req_ready,
   output mem_pkg::mem_req_t    req,

   input  logic                 rsp_valid,
   output logic                 rsp_ready,
   input  mem_pkg::mem_rsp_t    rsp,

   output logic                 out_valid,
   input  logic                 out_ready,
   output task_pkg::rw_write_t  out,
   input  mem_pkg::occ_t        out_occupancy
);

   mem_pkg::occ_t out_thresh;
   logic [31:0] dequeues_remaining;
   logic cfg_hit;
   logic can_dequeue;
   logic is_restore;
   logic bypass;
   logic hold_free;
   logic req_pending;
   logic task_fire;
   logic out_fire;

   task_pkg::task_t ctx_task [task_pkg::N_THREADS];
   mem_pkg::mem_addr_t ctx_addr [task_pkg::N_THREADS];
   task_pkg::cq_slot_t ctx_slot [task_pkg::N_THREADS];

   task_pkg::data_t undo_data [task_pkg::N_SLOTS];
   mem_pkg::mem_addr_t undo_addr [task_pkg::N_SLOTS];
   task_pkg::data_t undo_rd_data;

   logic hold_valid;
   task_pkg::rw_write_t hold_rec;
   task_pkg::rw_write_t rsp_rec;
   logic [mem_pkg::WORD_SEL_BITS-1:0] word_sel;

   // A request already offered keeps its place even if the output queue crosses the threshold
   assign can_dequeue = (dequeues_remaining != '0) &&
                        ((out_occupancy < out_thresh) || req_pending ||
                         (gvt_slot_valid && (gvt_slot == cq_slot_in)));

   assign is_restore = (task_in.ttype == task_pkg::TASK_TYPE_UNDO_LOG_RESTORE);
   assign bypass = task_in.no_read || is_restore;          // These tasks never touch memory
   assign hold_free = !out_valid || out_ready;             // Output payload must not change under a stall

   always_comb begin
      req_valid = 1'b0;
      task_in_ready = 1'b0;
      if (task_in_valid && can_dequeue) begin
         if (bypass) begin
            task_in_ready = hold_free;
         end else begin
            req_valid = 1'b1;
            task_in_ready = req_ready;
         end
      end
   end

   assign req = '{addr: araddr, id: thread_id_in};

   assign task_fire = task_in_valid && task_in_ready;
   assign out_fire = out_valid && out_ready;

   assign cfg_hit = cfg.valid && ((cfg.addr == mem_pkg::REG_N_DEQUEUES) ||
                                  (cfg.addr == mem_pkg::REG_FIFO_OUT_THRESH));

   always_ff @(posedge clk) begin
      if (!rstn) begin
         out_thresh <= '1;
         dequeues_remaining <= '1;
         req_pending <= 1'b0;
      end else begin
         req_pending <= req_valid && !req_ready;
         if (cfg_hit) begin
            case (cfg.addr)
               mem_pkg::REG_N_DEQUEUES: dequeues_remaining <= cfg.data;
               default:                 out_thresh <= mem_pkg::occ_t'(cfg.data);
            endcase
         end else if (task_fire) begin
            dequeues_remaining <= dequeues_remaining - 1'b1;
         end
      end
   end

   // Thread context for the response, and the slot's last read address for later restores
   always_ff @(posedge clk) begin
      if (req_valid && req_ready) begin
         ctx_task[thread_id_in] <= task_in;
         ctx_addr[thread_id_in] <= araddr;
         ctx_slot[thread_id_in] <= cq_slot_in;
         undo_addr[cq_slot_in] <= araddr;
      end
      if (out_fire) begin
         undo_data[out.cq_slot] <= out.data;               // Every record leaving updates its slot
      end
   end

   // A record leaving this edge for the same slot is newer than the stored entry
   assign undo_rd_data = (out_fire && (out.cq_slot == cq_slot_in)) ? out.data :
                                                                      undo_data[cq_slot_in];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         hold_valid <= 1'b0;
      end else if (task_fire && bypass) begin
         hold_valid <= 1'b1;
      end else if (out_fire) begin
         hold_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (task_fire && bypass) begin
         hold_rec.task_desc <= task_in;
         hold_rec.cq_slot <= cq_slot_in;
         hold_rec.thread <= thread_id_in;
         hold_rec.data <= '0;                              // No-read tasks carry no data
         if (is_restore) begin
            hold_rec.task_desc.object <= task_pkg::object_t'(undo_addr[cq_slot_in]);
            hold_rec.data <= undo_rd_data;
         end
      end
   end

   always_comb begin
      word_sel = ctx_addr[rsp.id][mem_pkg::LOG_LINE_BYTES-1:mem_pkg::LOG_RW_WIDTH];
      rsp_rec.task_desc = ctx_task[rsp.id];
      rsp_rec.cq_slot = ctx_slot[rsp.id];
      rsp_rec.thread = rsp.id;
      rsp_rec.data = rsp.line[word_sel*mem_pkg::RW_BITS +: mem_pkg::RW_BITS];
   end

   // Held bypass record wins over a waiting memory response
   assign out_valid = hold_valid || rsp_valid;
   assign out = hold_valid ? hold_rec : rsp_rec;
   assign rsp_ready = out_ready && !hold_valid;

endmodule

/* design/rw_read_top.sv */
// Read stage top level with address generator, request queue, object memory and output queue
module rw_read_top (
   input  logic                 clk,
   input  logic                 rstn,
   input  mem_pkg::cfg_wr_t     cfg,

   input  logic                 preload_valid,
   input  mem_pkg::mem_index_t  preload_index,
   input  mem_pkg::line_t       preload_line,

   input  logic                 task_in_valid,
   output logic                 task_in_ready,
   input  task_pkg::task_t      task_in,
   input  task_pkg::cq_slot_t   cq_slot_in,
   input  task_pkg::thread_id_t thread_id_in,

   input  logic                 gvt_slot_valid,
   input  task_pkg::cq_slot_t   gvt_slot,

   output logic                 out_valid,
   input  logic                 out_ready,
   output task_pkg::rw_write_t  out
);

   mem_pkg::mem_addr_t araddr;

   logic stage_req_valid;
   logic stage_req_ready;
   mem_pkg::mem_req_t stage_req;

   logic mem_req_valid;
   logic mem_req_ready;
   mem_pkg::mem_req_t mem_req;

   logic rsp_valid;
   logic rsp_ready;
   mem_pkg::mem_rsp_t rsp;

   logic stage_out_valid;
   logic stage_out_ready;
   task_pkg::rw_write_t stage_out;
   mem_pkg::occ_t out_occupancy;

   rw_addr_gen addr_gen (
      .clk     (clk),
      .rstn    (rstn),
      .cfg     (cfg),
      .task_in (task_in),
      .araddr  (araddr)
   );

   rw_read_stage read_stage (
      .clk            (clk),
      .rstn           (rstn),
      .cfg            (cfg),
      .task_in_valid  (task_in_valid),
      .task_in_ready  (task_in_ready),
      .task_in        (task_in),
      .cq_slot_in     (cq_slot_in),
      .thread_id_in   (thread_id_in),
      .araddr         (araddr),
      .gvt_slot_valid (gvt_slot_valid),
      .gvt_slot       (gvt_slot),
      .req_valid      (stage_req_valid),
      .req_ready      (stage_req_ready),
      .req            (stage_req),
      .rsp_valid      (rsp_valid),
      .rsp_ready      (rsp_ready),
      .rsp            (rsp),
      .out_valid      (stage_out_valid),
      .out_ready      (stage_out_ready),
      .out            (stage_out),
      .out_occupancy  (out_occupancy)
   );

   sync_queue #(.payload_t(mem_pkg::mem_req_t)) req_queue (
      .clk       (clk),
      .rstn      (rstn),
      .in_valid  (stage_req_valid),
      .in_ready  (stage_req_ready),
      .in_data   (stage_req),
      .out_valid (mem_req_valid),
      .out_ready (mem_req_ready),
      .out_data  (mem_req),
      .occupancy ()
   );

   object_memory obj_mem (
      .clk           (clk),
      .rstn          (rstn),
      .preload_valid (preload_valid),
      .preload_index (preload_index),
      .preload_line  (preload_line),
      .req_valid     (mem_req_valid),
      .req_ready     (mem_req_ready),
      .req           (mem_req),
      .rsp_valid     (rsp_valid),
      .rsp_ready     (rsp_ready),
      .rsp           (rsp)
   );

   sync_queue #(.payload_t(task_pkg::rw_write_t)) out_queue (
      .clk       (clk),
      .rstn      (rstn),
      .in_valid  (stage_out_valid),
      .in_ready  (stage_out_ready),
      .in_data   (stage_out),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out),
      .occupancy (out_occupancy)
   );

endmodule

/* verif/rw_read_assertions.sv */
// Concurrent handshake, gating and reset assertions for the read stage, with their bind
module rw_read_assertions (
   input logic              clk,
   input logic              rstn,
   input mem_pkg::cfg_wr_t  cfg,
   input logic              task_in_valid,
   input logic              task_in_ready,
   input logic [31:0]       dequeues_remaining,
   input logic              req_valid,
   input logic              req_ready,
   input mem_pkg::mem_req_t req,
   input logic              out_valid,
   input logic              out_ready
);
   timeunit 1ns;
   timeprecision 100ps;

   // An accepted task needs budget left and spends exactly one dequeue of it
   budget_gate: assert property (@(posedge clk) disable iff (!rstn)
      (task_in_valid && task_in_ready && !cfg.valid) |->
         (dequeues_remaining != '0) ##1
         (dequeues_remaining == $past(dequeues_remaining) - 32'd1))
      else $error("task accepted without budget or budget not counted down");

   req_hold: assert property (@(posedge clk) disable iff (!rstn)
      (req_valid && !req_ready) |=> (req_valid && $stable(req)))
      else $error("req dropped or changed before its transfer");

   out_hold: assert property (@(posedge clk) disable iff (!rstn)
      (out_valid && !out_ready) |=> out_valid)
      else $error("out_valid dropped before its transfer");

   // Checked from the second reset cycle, once the flops have been cleared
   reset_quiet: assert property (@(posedge clk)
      (!rstn ##1 !rstn) |-> (!req_valid && !out_valid && !task_in_ready))
      else $error("valid output high during reset");

endmodule

bind rw_read_stage rw_read_assertions protocol_checks (
   .clk                (clk),
   .rstn               (rstn),
   .cfg                (cfg),
   .task_in_valid      (task_in_valid),
   .task_in_ready      (task_in_ready),
   .dequeues_remaining (dequeues_remaining),
   .req_valid          (req_valid),
   .req_ready          (req_ready),
   .req                (req),
   .out_valid          (out_valid),
   .out_ready          (out_ready)
);

/* verif/rw_read_tb.sv */
// Testbench for rw_read_top with memory preload, reference model, record checker and timeout
module rw_read_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int TOTAL_TASKS = 84;
   localparam int TIMEOUT_CYCLES = 40 * TOTAL_TASKS + 200;
   localparam int ACCEPT_LIMIT = 100;
   localparam int WORDS_PER_LINE = mem_pkg::LINE_BITS / mem_pkg::RW_BITS;
   localparam int WORD_MSB = mem_pkg::LOG_LINE_BYTES + mem_pkg::LOG_MEM_LINES - 1;

   logic                 clk;
   logic                 rstn;
   mem_pkg::cfg_wr_t     cfg;
   logic                 preload_valid;
   mem_pkg::mem_index_t  preload_index;
   mem_pkg::line_t       preload_line;
   logic                 task_in_valid;
   logic                 task_in_ready;
   task_pkg::task_t      task_in;
   task_pkg::cq_slot_t   cq_slot_in;
   task_pkg::thread_id_t thread_id_in;
   logic                 gvt_slot_valid;
   task_pkg::cq_slot_t   gvt_slot;
   logic                 out_valid;
   logic                 out_ready;
   task_pkg::rw_write_t  out;

   logic [31:0] rng;
   logic [31:0] bp_state;
   bit bp_enable;
   int bp_left;
   int cycle_count;

   logic [31:0] mem_image [mem_pkg::MEM_LINES * WORDS_PER_LINE];
   mem_pkg::mem_addr_t model_base;
   task_pkg::data_t model_undo_data [task_pkg::N_SLOTS];     // Last data seen leaving per slot
   mem_pkg::mem_addr_t model_undo_addr [task_pkg::N_SLOTS];

   task_pkg::rw_write_t exp_rec [task_pkg::N_THREADS];
   bit [task_pkg::N_THREADS-1:0] exp_check_data;
   bit [task_pkg::N_THREADS-1:0] exp_pending;
   task_pkg::thread_id_t next_thread;

   int errors;
   int records;
   int test_start_errors;
   int test_start_records;
   int n_tests;
   int tests_clean;

   rw_read_top dut (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // Expected record from the preloaded image and the undo-log model
   function automatic task_pkg::rw_write_t expected_record(input task_pkg::task_t t,
                                                           input task_pkg::cq_slot_t slot,
                                                           input task_pkg::thread_id_t thr,
                                                           input mem_pkg::mem_addr_t base);
      task_pkg::rw_write_t rec;
      mem_pkg::mem_addr_t addr;
      addr = base + (mem_pkg::mem_addr_t'(t.object) << mem_pkg::LOG_RW_WIDTH);
      rec.task_desc = t;
      rec.cq_slot = slot;
      rec.thread = thr;
      rec.data = mem_image[addr[WORD_MSB:mem_pkg::LOG_RW_WIDTH]];
      if (t.ttype == task_pkg::TASK_TYPE_UNDO_LOG_RESTORE) begin
         rec.task_desc.object = model_undo_addr[slot][15:0];
         rec.data = model_undo_data[slot];
      end else if (t.no_read) begin
         rec.data = '0;
      end
      return rec;
   endfunction

   function automatic task_pkg::task_t random_task(input task_pkg::ttype_t ttype,
                                                   input logic no_read);
      task_pkg::task_t t;
      rng = lcg_next(rng);
      t.object = rng[31:16];
      t.ts = rng[23:8];
      t.ttype = ttype;
      t.no_read = no_read;
      return t;
   endfunction

   function automatic task_pkg::cq_slot_t random_slot();
      rng = lcg_next(rng);
      return rng[27:24];
   endfunction

   task automatic step_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic report_failure(input string msg);
      $display("%0t ns: %s", $time, msg);
      errors++;
   endtask

   task automatic report_mismatch(input string field, input logic [63:0] expected,
                                  input logic [63:0] actual);
      $display("[FAIL] %0t ns: %s expected 0x%0h, got 0x%0h", $time, field, expected, actual);
      errors++;
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      cfg = '{valid: 1'b1, addr: addr, data: data};
      step_cycle();
      cfg.valid = 1'b0;
      if (addr == mem_pkg::REG_RW_BASE_ADDR) begin
         model_base = {data[31:2], 2'b00};
      end
   endtask

   task automatic preload_memory();
      mem_pkg::line_t line;
      for (int i = 0; i < mem_pkg::MEM_LINES; i++) begin
         for (int w = 0; w < WORDS_PER_LINE; w++) begin
            rng = lcg_next(rng);
            mem_image[i * WORDS_PER_LINE + w] = rng;
            line[w * mem_pkg::RW_BITS +: mem_pkg::RW_BITS] = rng;
         end
         preload_valid = 1'b1;
         preload_index = mem_pkg::mem_index_t'(i);
         preload_line = line;
         step_cycle();
      end
      preload_valid = 1'b0;
   endtask

   task automatic offer_task(input task_pkg::task_t t, input task_pkg::cq_slot_t slot,
                             input int limit, output bit accepted);
      task_pkg::thread_id_t thr;
      int waited;
      thr = next_thread;
      next_thread = next_thread + 1'b1;
      while (exp_pending[thr]) begin
         step_cycle();                                     // Thread id stays busy until its record returns
      end
      exp_rec[thr] = expected_record(t, slot, thr, model_base);
      exp_check_data[thr] = !t.no_read;
      exp_pending[thr] = 1'b1;
      task_in_valid = 1'b1;
      task_in = t;
      cq_slot_in = slot;
      thread_id_in = thr;
      accepted = 1'b0;
      waited = 0;
      while (!accepted && (waited < limit)) begin
         @(negedge clk);
         accepted = task_in_ready;
         step_cycle();
         waited++;
      end
      task_in_valid = 1'b0;
      if (!accepted) begin
         exp_pending[thr] = 1'b0;
      end else if (!t.no_read && (t.ttype != task_pkg::TASK_TYPE_UNDO_LOG_RESTORE)) begin
         model_undo_addr[slot] = model_base +
                                 (mem_pkg::mem_addr_t'(t.object) << mem_pkg::LOG_RW_WIDTH);
      end
   endtask

   task automatic send_task(input task_pkg::task_t t, input task_pkg::cq_slot_t slot);
      bit accepted;
      offer_task(t, slot, ACCEPT_LIMIT, accepted);
      if (!accepted) begin
         report_failure($sformatf("task on slot %0d was not accepted in time", slot));
      end
   endtask

   task automatic drain();
      while (exp_pending != '0) begin
         step_cycle();
      end
   endtask

   task automatic finish_test(input string name, input int expected_records);
      drain();
      if ((records - test_start_records) != expected_records) begin
         report_mismatch("record count", expected_records, records - test_start_records);
      end
      $display("%s: %0d records, %0d errors", name, records - test_start_records,
               errors - test_start_errors);
      if (errors == test_start_errors) begin
         tests_clean++;
      end
      n_tests++;
      test_start_errors = errors;
      test_start_records = records;
   endtask

   // Random stretches of out_ready low while back-pressure is on
   always @(posedge clk) begin : drive_back_pressure
      bit enabled;
      enabled = bp_enable;
      #2;
      if (!enabled) begin
         out_ready = 1'b1;
         bp_left = 0;
      end else if (bp_left == 0) begin
         bp_state = lcg_next(bp_state);
         out_ready = bp_state[31];
         bp_left = int'(bp_state[29:27]);               // Stretches of 1 to 8 cycles
      end else begin
         bp_left--;
      end
   end

   always @(negedge clk) begin : check_output
      task_pkg::thread_id_t thr;
      task_pkg::rw_write_t want;
      if (rstn && out_valid && out_ready) begin
         thr = out.thread;
         if ($isunknown(thr) || !exp_pending[thr]) begin
            report_failure($sformatf("record on thread %0d arrived with no task outstanding",
                                     thr));
         end else begin
            want = exp_rec[thr];
            if (out.task_desc !== want.task_desc) begin
               report_mismatch("out.task_desc", want.task_desc, out.task_desc);
            end
            if (out.cq_slot !== want.cq_slot) begin
               report_mismatch("out.cq_slot", want.cq_slot, out.cq_slot);
            end
            if (exp_check_data[thr] && (out.data !== want.data)) begin
               report_mismatch("out.data", want.data, out.data);
            end
            if (exp_check_data[thr]) begin
               model_undo_data[want.cq_slot] = want.data;
            end
            exp_pending[thr] = 1'b0;
            records++;
         end
      end
   end

   initial begin
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      task_pkg::task_t t;
      task_pkg::cq_slot_t slot;
      bit acc;
      rng = 32'h27806d84;
      bp_state = 32'h27806d84;
      rstn = 1'b0;
      cfg = '0;
      preload_valid = 1'b0;
      preload_index = '0;
      preload_line = '0;
      task_in_valid = 1'b0;
      task_in = '0;
      cq_slot_in = '0;
      thread_id_in = '0;
      gvt_slot_valid = 1'b0;
      gvt_slot = '0;
      out_ready = 1'b1;
      model_base = '0;
      repeat (10) @(posedge clk);
      #2;
      rstn = 1'b1;
      preload_memory();

      write_reg(mem_pkg::REG_RW_BASE_ADDR, 32'h0000_0340);
      for (int i = 0; i < 40; i++) begin
         if (i == 20) begin
            drain();
            write_reg(mem_pkg::REG_RW_BASE_ADDR, 32'h0001_2a07);   // Low bits are dropped
         end
         t = random_task(task_pkg::TASK_TYPE_NORMAL, 1'b0);
         slot = random_slot();
         send_task(t, slot);
      end
      finish_test("normal reads", 40);

      for (int s = 1; s <= 3; s++) begin
         send_task(random_task(task_pkg::TASK_TYPE_NORMAL, 1'b0), task_pkg::cq_slot_t'(s));
      end
      drain();
      for (int s = 9; s <= 11; s++) begin
         send_task(random_task(task_pkg::ttype_t'(1), 1'b1), task_pkg::cq_slot_t'(s));
      end
      drain();
      for (int s = 1; s <= 3; s++) begin
         send_task(random_task(task_pkg::TASK_TYPE_UNDO_LOG_RESTORE, 1'b0),
                   task_pkg::cq_slot_t'(s));
      end
      send_task(random_task(task_pkg::TASK_TYPE_UNDO_LOG_RESTORE, 1'b0), 4'd2);
      finish_test("no-read and restore", 10);

      write_reg(mem_pkg::REG_N_DEQUEUES, 32'd5);
      for (int i = 0; i < 8; i++) begin
         t = random_task(task_pkg::TASK_TYPE_NORMAL, 1'b0);
         slot = random_slot();
         offer_task(t, slot, ACCEPT_LIMIT, acc);
         if ((i < 5) && !acc) begin
            report_failure($sformatf("task %0d was refused inside the dequeue budget", i));
         end
         if ((i >= 5) && acc) begin
            report_failure($sformatf("task %0d was accepted after the budget ran out", i));
         end
      end
      finish_test("dequeue budget", 5);
      write_reg(mem_pkg::REG_N_DEQUEUES, '1);

      write_reg(mem_pkg::REG_FIFO_OUT_THRESH, 32'd2);
      bp_enable = 1'b1;
      for (int i = 0; i < 24; i++) begin
         if ((i % 4) == 3) begin
            t = random_task(task_pkg::ttype_t'(1), 1'b1);
         end else begin
            t = random_task(task_pkg::TASK_TYPE_NORMAL, 1'b0);
         end
         slot = random_slot();
         send_task(t, slot);
      end
      finish_test("back-pressure", 24);
      bp_enable = 1'b0;
      write_reg(mem_pkg::REG_FIFO_OUT_THRESH, '1);

      write_reg(mem_pkg::REG_FIFO_OUT_THRESH, 32'd0);
      gvt_slot_valid = 1'b1;
      gvt_slot = 4'd5;
      offer_task(random_task(task_pkg::TASK_TYPE_NORMAL, 1'b0), 4'd5, ACCEPT_LIMIT, acc);
      if (!acc) begin
         report_failure("task on the GVT slot was not accepted with the gate closed");
      end
      offer_task(random_task(task_pkg::TASK_TYPE_NORMAL, 1'b0), 4'd6, ACCEPT_LIMIT, acc);
      if (acc) begin
         report_failure("task on a non-GVT slot was accepted with the gate closed");
      end
      finish_test("gvt override", 1);
      gvt_slot_valid = 1'b0;
      write_reg(mem_pkg::REG_FIFO_OUT_THRESH, '1);

      $display("Summary: %0d of %0d tests clean, %0d records checked, %0d errors",
               tests_clean, n_tests, records, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* list.f */
design/task_pkg.sv
design/mem_pkg.sv
design/sync_queue.sv
design/rw_addr_gen.sv
design/object_memory.sv
design/rw_read_stage.sv
design/rw_read_top.sv
verif/rw_read_assertions.sv
verif/rw_read_tb.sv
